//--- dcache_config.svh
`ifndef DCACHE_CONFIG_SVH
`define DCACHE_CONFIG_SVH

// pipeline word and address widths
`define DC_XLEN 64
`define DC_ADDR_W 32

// cache geometry
`define DC_SETS 64
`define DC_LINE_BITS 256
`define DC_WAYS 2

// memory beats per line refill
`define DC_BEATS 4

`endif

//--- dcachePkg.sv
`include "dcache_config.svh"

package dcachePkg;

  localparam int BYTE_OFF_W = $clog2(`DC_XLEN / 8);
  localparam int WORD_SEL_W = $clog2(`DC_LINE_BITS / `DC_XLEN);
  localparam int INDEX_W = $clog2(`DC_SETS);
  localparam int TAG_W = `DC_ADDR_W - INDEX_W - WORD_SEL_W - BYTE_OFF_W;

  typedef logic [`DC_LINE_BITS-1:0] dcLine_t;
  // bit mask over a whole line
  typedef logic [`DC_LINE_BITS-1:0] dcMask_t;
  typedef logic [INDEX_W-1:0] dcIndex_t;
  typedef logic [TAG_W-1:0] dcTag_t;

  typedef struct packed {
    dcTag_t                tag;
    dcIndex_t              index;
    logic [WORD_SEL_W-1:0] wordSel;
    logic [BYTE_OFF_W-1:0] byteOff;
  } dcAddrFields_t;

  // raw word for memory addresses, field view for the lookup
  typedef union packed {
    logic [`DC_ADDR_W-1:0] raw;
    dcAddrFields_t         fld;
  } dcAddr_u;

  typedef enum logic [2:0] {
    IDLE,
    COMPARE,
    WRBACK,
    MISS,
    GETDATA,
    REPLACE,
    RELOOK
  } dcState_e;

endpackage

//--- sramIf.sv
`timescale 1ns/1ps

interface sramIf;

  import dcachePkg::*;

  logic     ce;
  logic     we;
  dcIndex_t index;
  dcLine_t  wdata;
  // set bits select which bits a write updates
  dcMask_t  wmask;
  // registered, valid one cycle after a read
  dcLine_t  rdata;

  modport ctrl (
    output ce, we, index, wdata, wmask,
    input  rdata
  );

  modport ram (
    input  ce, we, index, wdata, wmask,
    output rdata
  );

endinterface

//--- dataRam.sv
`timescale 1ns/1ps
`include "dcache_config.svh"

module dataRam (
  input logic clk,
  sramIf.ram  ram
);

  import dcachePkg::*;

  dcLine_t mem [`DC_SETS];
  dcLine_t oldLine;
  dcLine_t newLine;

  // read-modify-write under the bit mask
  assign oldLine = mem[ram.index];
  assign newLine = (oldLine & ~ram.wmask) | (ram.wdata & ram.wmask);

  always_ff @(posedge clk) begin
    if (ram.ce) begin
      if (ram.we) begin
        mem[ram.index] <= newLine;
      end else begin
        ram.rdata <= oldLine;
      end
    end
  end

  // selected set must be known whenever the macro is enabled
  assert property (@(posedge clk) ram.ce |-> !$isunknown(ram.index));

endmodule

//--- refillBuffer.sv
`timescale 1ns/1ps
`include "dcache_config.svh"

module refillBuffer (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                collect_i,
  input  logic                beatValid_i,
  input  logic [`DC_XLEN-1:0] beatData_i,
  output logic                complete_o,
  output dcachePkg::dcLine_t  line_o
);

  localparam int CNT_W = $clog2(`DC_BEATS);

  logic [CNT_W-1:0] beatCnt;
  logic             takeBeat;
  logic             lastBeat;
  logic             lineFull;

  // beats outside the collect window are dropped
  assign takeBeat = collect_i && beatValid_i;
  assign lastBeat = takeBeat && (beatCnt == CNT_W'(`DC_BEATS - 1));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      beatCnt    <= '0;
      lineFull   <= 1'b0;
      complete_o <= 1'b0;
    end else begin
      complete_o <= lastBeat;
      if (!collect_i) begin
        beatCnt  <= '0;
        lineFull <= 1'b0;
      end else if (takeBeat) begin
        beatCnt <= beatCnt + 1'b1;
        if (lastBeat) begin
          lineFull <= 1'b1;
        end
      end
    end
  end

  // beat n lands in word slot n
  always_ff @(posedge clk) begin
    if (takeBeat) begin
      line_o[beatCnt*`DC_XLEN +: `DC_XLEN] <= beatData_i;
    end
  end

  // a fifth beat would wrap and clobber word 0
  assert property (@(posedge clk) disable iff (!rst_n)
    (lineFull && collect_i) |-> !beatValid_i);

endmodule

//--- dcacheCtrl.sv
`timescale 1ns/1ps
`include "dcache_config.svh"

module dcacheCtrl (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    valid_i,
  input  logic                    op_i,
  input  logic [`DC_ADDR_W-1:0]   addr_i,
  input  logic [`DC_XLEN-1:0]     wrData_i,
  input  logic [`DC_XLEN/8-1:0]   wrMask_i,
  input  logic                    stall_n,
  output logic                    addrOk_o,
  output logic                    dataOk_o,
  output logic [`DC_XLEN-1:0]     rdData_o,
  output logic                    rdValid_o,
  input  logic                    rdReady_i,
  output logic [`DC_ADDR_W-1:0]   rdAddr_o,
  input  logic                    rdLast_i,
  output logic                    wrValid_o,
  input  logic                    wrReady_i,
  output logic [`DC_ADDR_W-1:0]   wrAddr_o,
  output dcachePkg::dcLine_t      wrData_o,
  output logic                    collect_o,
  input  logic                    refillDone_i,
  input  dcachePkg::dcLine_t      refillLine_i,
  sramIf.ctrl                     way0,
  sramIf.ctrl                     way1
);

  import dcachePkg::*;

  dcState_e                          state;
  dcState_e                          nextState;
  dcAddr_u                           newAddr;
  dcAddr_u                           reqAddr;
  logic                              reqOp;
  logic [`DC_XLEN-1:0]               reqData;
  logic [`DC_XLEN/8-1:0]             reqMask;
  logic [`DC_WAYS-1:0][`DC_SETS-1:0] validArr;
  logic [`DC_WAYS-1:0][`DC_SETS-1:0] dirtyArr;
  dcTag_t                            tagArr [`DC_WAYS][`DC_SETS];
  dcLine_t                           wayData [`DC_WAYS];
  logic [`DC_WAYS-1:0]               hitVec;
  logic                              hit;
  logic                              hitWay;
  logic                              accept;
  logic                              storeHit;
  logic [7:0]                        lfsr;
  logic                              victimPick;
  logic                              victimWay;
  dcAddr_u                           rdBase;
  dcAddr_u                           wbBase;
  logic [`DC_XLEN-1:0]               byteBits;
  logic [`DC_XLEN-1:0]               storeWord;
  dcLine_t                           storeLine;
  dcMask_t                           storeMask;
  logic [`DC_WAYS-1:0]               ramCe;
  logic [`DC_WAYS-1:0]               ramWe;
  dcIndex_t                          ramIdx;
  dcLine_t                           ramWdata;
  dcMask_t                           ramWmask;

  assign newAddr.raw = addr_i;
  assign wayData[0] = way0.rdata;
  assign wayData[1] = way1.rdata;

  // tag compare on the latched request
  always_comb begin
    for (int w = 0; w < `DC_WAYS; w++) begin
      hitVec[w] = validArr[w][reqAddr.fld.index] &&
                  (tagArr[w][reqAddr.fld.index] == reqAddr.fld.tag);
    end
  end

  assign hit = |hitVec;
  assign hitWay = hitVec[1];
  assign addrOk_o = (state == IDLE) || ((state == COMPARE) && hit);
  assign dataOk_o = (state == COMPARE) && hit && stall_n;
  assign accept = valid_i && addrOk_o && stall_n;
  assign storeHit = dataOk_o && reqOp;
  assign rdData_o = wayData[hitWay][reqAddr.fld.wordSel*`DC_XLEN +: `DC_XLEN];

  // invalid way first, random otherwise
  assign victimPick = !validArr[0][reqAddr.fld.index] ? 1'b0 :
                      !validArr[1][reqAddr.fld.index] ? 1'b1 : lfsr[0];

  always_comb begin
    nextState = state;
    case (state)
      IDLE: begin
        if (accept) begin
          nextState = COMPARE;
        end
      end
      COMPARE: begin
        if (!hit) begin
          nextState = dirtyArr[victimPick][reqAddr.fld.index] ? WRBACK : MISS;
        end else if (stall_n) begin
          // a store hit owns the RAM this cycle, so the next lookup reads later
          if (accept) begin
            nextState = reqOp ? RELOOK : COMPARE;
          end else begin
            nextState = IDLE;
          end
        end
      end
      WRBACK: begin
        if (wrReady_i) begin
          nextState = MISS;
        end
      end
      MISS: begin
        if (rdReady_i) begin
          nextState = GETDATA;
        end
      end
      GETDATA: begin
        if (refillDone_i) begin
          nextState = REPLACE;
        end
      end
      REPLACE: nextState = RELOOK;
      RELOOK: nextState = COMPARE;
      default: nextState = IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state     <= IDLE;
      lfsr      <= 8'hA5;
      victimWay <= 1'b0;
    end else begin
      state <= nextState;
      lfsr  <= {lfsr[6:0], lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3]};
      if ((state == COMPARE) && !hit) begin
        victimWay <= victimPick;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      reqAddr <= newAddr;
      reqOp   <= op_i;
      reqData <= wrData_i;
      reqMask <= wrMask_i;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      validArr <= '0;
      dirtyArr <= '0;
    end else if (state == REPLACE) begin
      validArr[victimWay][reqAddr.fld.index] <= 1'b1;
      dirtyArr[victimWay][reqAddr.fld.index] <= 1'b0;
    end else if (storeHit) begin
      dirtyArr[hitWay][reqAddr.fld.index] <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (state == REPLACE) begin
      tagArr[victimWay][reqAddr.fld.index] <= reqAddr.fld.tag;
    end
  end

  // store data arrives right-aligned, mask is already in byte lanes
  always_comb begin
    for (int b = 0; b < `DC_XLEN / 8; b++) begin
      byteBits[b*8 +: 8] = {8{reqMask[b]}};
    end
  end

  assign storeWord = reqData << {reqAddr.fld.byteOff, 3'b000};
  assign storeLine = {(`DC_LINE_BITS / `DC_XLEN){storeWord}};
  assign storeMask = dcMask_t'(byteBits) << (reqAddr.fld.wordSel * `DC_XLEN);

  always_comb begin
    ramCe    = '0;
    ramWe    = '0;
    ramIdx   = reqAddr.fld.index;
    ramWdata = storeLine;
    ramWmask = storeMask;
    if (state == REPLACE) begin
      ramCe[victimWay] = 1'b1;
      ramWe[victimWay] = 1'b1;
      ramWdata         = refillLine_i;
      ramWmask         = '1;
    end else if (storeHit) begin
      ramCe[hitWay] = 1'b1;
      ramWe[hitWay] = 1'b1;
    end else if (state == RELOOK) begin
      ramCe = '1;
    end else if (accept) begin
      ramCe  = '1;
      ramIdx = newAddr.fld.index;
    end
  end

  assign way0.ce    = ramCe[0];
  assign way0.we    = ramWe[0];
  assign way0.index = ramIdx;
  assign way0.wdata = ramWdata;
  assign way0.wmask = ramWmask;
  assign way1.ce    = ramCe[1];
  assign way1.we    = ramWe[1];
  assign way1.index = ramIdx;
  assign way1.wdata = ramWdata;
  assign way1.wmask = ramWmask;

  // line base of the request, then of the victim
  always_comb begin
    rdBase             = reqAddr;
    rdBase.fld.wordSel = '0;
    rdBase.fld.byteOff = '0;
    wbBase             = rdBase;
    wbBase.fld.tag     = tagArr[victimWay][reqAddr.fld.index];
  end

  assign rdValid_o = (state == MISS);
  assign rdAddr_o  = rdBase.raw;
  assign wrValid_o = (state == WRBACK);
  assign wrAddr_o  = wbBase.raw;
  // RAM output holds the victim line from the lookup read
  assign wrData_o  = wayData[victimWay];
  assign collect_o = (state == GETDATA);

  // refill is requested only once a dirty victim has gone out
  assert property (@(posedge clk) disable iff (!rst_n)
    $rose(rdValid_o) |-> $past(wrValid_o) || !dirtyArr[victimWay][reqAddr.fld.index]);

  // every result follows a cycle that issued or held the lookup read
  assert property (@(posedge clk) disable iff (!rst_n)
    dataOk_o |-> $past((&ramCe) && !(|ramWe)) || $past((state == COMPARE) && !dataOk_o));

  // buffer completion lines up with the memory's last beat
  assert property (@(posedge clk) disable iff (!rst_n) refillDone_i |-> $past(rdLast_i));

endmodule

//--- dcacheTop.sv
`timescale 1ns/1ps
`include "dcache_config.svh"

module dcacheTop (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      valid_i,
  input  logic                      op_i,
  input  logic [`DC_ADDR_W-1:0]     addr_i,
  input  logic [`DC_XLEN-1:0]       wrData_i,
  input  logic [`DC_XLEN/8-1:0]     wrMask_i,
  input  logic                      stall_n,
  output logic                      addrOk_o,
  output logic                      dataOk_o,
  output logic [`DC_XLEN-1:0]       rdData_o,
  output logic                      rdValid_o,
  input  logic                      rdReady_i,
  output logic [`DC_ADDR_W-1:0]     rdAddr_o,
  input  logic                      rdLast_i,
  input  logic [`DC_XLEN-1:0]       rdData_i,
  input  logic                      dataValid_i,
  output logic                      wrValid_o,
  input  logic                      wrReady_i,
  output logic [`DC_ADDR_W-1:0]     wrAddr_o,
  output logic [`DC_LINE_BITS-1:0]  wrData_o
);

  import dcachePkg::*;

  logic    collect;
  logic    refillDone;
  dcLine_t refillLine;

  // one RAM port per way
  sramIf ramIf0 ();
  sramIf ramIf1 ();

  dcacheCtrl ctrl0 (
    .clk          (clk),
    .rst_n        (rst_n),
    .valid_i      (valid_i),
    .op_i         (op_i),
    .addr_i       (addr_i),
    .wrData_i     (wrData_i),
    .wrMask_i     (wrMask_i),
    .stall_n      (stall_n),
    .addrOk_o     (addrOk_o),
    .dataOk_o     (dataOk_o),
    .rdData_o     (rdData_o),
    .rdValid_o    (rdValid_o),
    .rdReady_i    (rdReady_i),
    .rdAddr_o     (rdAddr_o),
    .rdLast_i     (rdLast_i),
    .wrValid_o    (wrValid_o),
    .wrReady_i    (wrReady_i),
    .wrAddr_o     (wrAddr_o),
    .wrData_o     (wrData_o),
    .collect_o    (collect),
    .refillDone_i (refillDone),
    .refillLine_i (refillLine),
    .way0         (ramIf0.ctrl),
    .way1         (ramIf1.ctrl)
  );

  refillBuffer refill0 (
    .clk         (clk),
    .rst_n       (rst_n),
    .collect_i   (collect),
    .beatValid_i (dataValid_i),
    .beatData_i  (rdData_i),
    .complete_o  (refillDone),
    .line_o      (refillLine)
  );

  dataRam ram0 (
    .clk (clk),
    .ram (ramIf0.ram)
  );

  dataRam ram1 (
    .clk (clk),
    .ram (ramIf1.ram)
  );

endmodule

//--- tb_dcache.sv
`timescale 1ns/1ps
`include "dcache_config.svh"

module tb_dcache;

  localparam int CLK_PERIOD = 100;
  localparam int NUM_REQ = 400;
  localparam logic [31:0] SEED = 32'h30ef_6382;

  logic clk;
  logic rst_n;
  logic valid_i;
  logic op_i;
  logic [`DC_ADDR_W-1:0] addr_i;
  logic [`DC_XLEN-1:0] wrData_i;
  logic [`DC_XLEN/8-1:0] wrMask_i;
  logic stall_n;
  logic addrOk_o;
  logic dataOk_o;
  logic [`DC_XLEN-1:0] rdData_o;
  logic rdValid_o;
  logic rdReady_i;
  logic [`DC_ADDR_W-1:0] rdAddr_o;
  logic rdLast_i;
  logic [`DC_XLEN-1:0] rdData_i;
  logic dataValid_i;
  logic wrValid_o;
  logic wrReady_i;
  logic [`DC_ADDR_W-1:0] wrAddr_o;
  logic [`DC_LINE_BITS-1:0] wrData_o;

  // reference model bytes and backing memory words, both sparse
  logic [7:0] refMem [logic [31:0]];
  logic [`DC_XLEN-1:0] backMem [logic [31:0]];
  logic [31:0] stimRnd = SEED;
  logic [31:0] memRnd = ~SEED;

  dcacheTop dut0 (
    .clk (clk), .rst_n (rst_n), .valid_i (valid_i), .op_i (op_i), .addr_i (addr_i),
    .wrData_i (wrData_i), .wrMask_i (wrMask_i), .stall_n (stall_n),
    .addrOk_o (addrOk_o), .dataOk_o (dataOk_o), .rdData_o (rdData_o),
    .rdValid_o (rdValid_o), .rdReady_i (rdReady_i), .rdAddr_o (rdAddr_o),
    .rdLast_i (rdLast_i), .rdData_i (rdData_i), .dataValid_i (dataValid_i),
    .wrValid_o (wrValid_o), .wrReady_i (wrReady_i), .wrAddr_o (wrAddr_o),
    .wrData_o (wrData_o)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  task automatic failNow(input string msg);
    $display("%s", msg);
    $display("CHECKS FAILED");
    $fatal(1, "run stopped at first failure");
  endtask

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s ^ (s << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] drawStim();
    stimRnd = xorshift(stimRnd);
    return stimRnd;
  endfunction

  function automatic logic [31:0] drawMem();
    memRnd = xorshift(memRnd);
    return memRnd;
  endfunction

  // default memory content, a function of the whole word address
  function automatic logic [`DC_XLEN-1:0] fillWord(input logic [31:0] a);
    return {a ^ 32'hc3a5_0f1e, ~a};
  endfunction

  function automatic logic [`DC_XLEN-1:0] modelWord(input logic [31:0] a);
    logic [`DC_XLEN-1:0] w;
    w = fillWord(a);
    for (int b = 0; b < `DC_XLEN / 8; b++) begin
      if (refMem.exists(a + 32'(b))) begin
        w[b*8 +: 8] = refMem[a + 32'(b)];
      end
    end
    return w;
  endfunction

  function automatic logic [`DC_XLEN-1:0] memWord(input logic [31:0] a);
    return backMem.exists(a) ? backMem[a] : fillWord(a);
  endfunction

  function automatic void applyStore(input logic [31:0] a, input logic [63:0] d,
                                     input logic [7:0] m);
    for (int b = 0; b < `DC_XLEN / 8; b++) begin
      if (m[b]) begin
        refMem[a + 32'(b)] = d[b*8 +: 8];
      end
    end
  endfunction

  // four tags over two sets, so ways get evicted often
  function automatic logic [31:0] pickAddr();
    logic [20:0] tag;
    logic [5:0]  idx;
    case (drawStim() % 4)
      0: tag = 21'h00001;
      1: tag = 21'h0abcd;
      2: tag = 21'h1f00e;
      default: tag = 21'h12345;
    endcase
    idx = (drawStim() % 2 == 0) ? 6'd3 : 6'd42;
    return {tag, idx, 2'(drawStim()), 3'b000};
  endfunction

  task automatic serveWriteBack();
    logic [31:0] base;
    logic [`DC_XLEN-1:0] expWord;
    int delay;
    base = wrAddr_o;
    delay = drawMem() % 4;
    assert (base[4:0] == 5'd0)
      else failNow($sformatf("MISMATCH wrAddr_o expected=%h actual=%h", base & ~32'h1f, base));
    repeat (delay) begin
      @(negedge clk);
      assert (wrValid_o && wrAddr_o == base)
        else failNow("write-back request changed while wrReady_i was low");
    end
    @(posedge clk);
    #1;
    wrReady_i = 1'b1;
    @(negedge clk);
    for (int w = 0; w < `DC_BEATS; w++) begin
      expWord = modelWord(base + 32'(w * 8));
      assert (wrData_o[w*`DC_XLEN +: `DC_XLEN] === expWord)
        else failNow($sformatf("MISMATCH wrData_o addr=%h expected=%h actual=%h",
                               base + 32'(w * 8), expWord, wrData_o[w*`DC_XLEN +: `DC_XLEN]));
      backMem[base + 32'(w * 8)] = wrData_o[w*`DC_XLEN +: `DC_XLEN];
    end
    @(posedge clk);
    #1;
    wrReady_i = 1'b0;
  endtask

  task automatic serveRefill();
    logic [31:0] base;
    int delay;
    base = rdAddr_o;
    delay = drawMem() % 4;
    assert (base[4:0] == 5'd0)
      else failNow($sformatf("MISMATCH rdAddr_o expected=%h actual=%h", base & ~32'h1f, base));
    repeat (delay) begin
      @(negedge clk);
      assert (rdValid_o && rdAddr_o == base)
        else failNow("refill request changed while rdReady_i was low");
    end
    @(posedge clk);
    #1;
    rdReady_i = 1'b1;
    @(posedge clk);
    #1;
    rdReady_i = 1'b0;
    // beats with random gaps, last one flagged
    for (int b = 0; b < `DC_BEATS; b++) begin
      repeat (drawMem() % 3) begin
        dataValid_i = 1'b0;
        rdLast_i = 1'b0;
        @(posedge clk);
        #1;
      end
      dataValid_i = 1'b1;
      rdData_i = memWord(base + 32'(b * 8));
      rdLast_i = (b == `DC_BEATS - 1);
      @(posedge clk);
      #1;
    end
    dataValid_i = 1'b0;
    rdLast_i = 1'b0;
  endtask

  initial begin : memResponder
    rdReady_i = 1'b0;
    rdLast_i = 1'b0;
    rdData_i = '0;
    dataValid_i = 1'b0;
    wrReady_i = 1'b0;
    @(posedge rst_n);
    forever begin
      @(negedge clk);
      if (wrValid_o) begin
        serveWriteBack();
      end else if (rdValid_o) begin
        serveRefill();
      end
    end
  end

  always @(negedge clk) begin
    if (rst_n) begin
      assert (!(rdValid_o && wrValid_o))
        else failNow("rdValid_o and wrValid_o were high in the same cycle");
    end
  end

  initial begin : watchdog
    #(NUM_REQ * 200 * CLK_PERIOD);
    failNow("watchdog expired before all requests completed");
  end

  initial begin : stimulus
    logic [31:0] addr;
    logic [31:0] prevLine;
    logic prevValid;
    logic isStore;
    logic [63:0] data;
    logic [7:0] mask;
    logic [63:0] expWord;
    logic sameLine;
    logic done;
    int holdCycles;
    int waitCycles;
    valid_i = 1'b0;
    op_i = 1'b0;
    addr_i = '0;
    wrData_i = '0;
    wrMask_i = '0;
    stall_n = 1'b1;
    rst_n = 1'b0;
    prevLine = '0;
    prevValid = 1'b0;
    repeat (3) @(posedge clk);
    #1;
    rst_n = 1'b1;
    @(negedge clk);
    assert (addrOk_o && !dataOk_o && !rdValid_o && !wrValid_o)
      else failNow($sformatf("bad state after reset: addrOk_o=%b dataOk_o=%b rdValid_o=%b wrValid_o=%b",
                             addrOk_o, dataOk_o, rdValid_o, wrValid_o));
    @(posedge clk);
    #1;
    for (int n = 0; n < NUM_REQ; n++) begin
      addr = pickAddr();
      isStore = (drawStim() % 10) < 4;
      data = {drawStim(), drawStim()};
      mask = 8'(drawStim());
      holdCycles = drawStim() % 3;
      sameLine = prevValid && ((addr & ~32'h1f) == prevLine);
      valid_i = 1'b1;
      op_i = isStore;
      addr_i = addr;
      wrData_i = data;
      wrMask_i = mask;
      stall_n = (holdCycles == 0);
      // request held off by stall_n must leave the cache idle
      for (int h = 0; h < holdCycles; h++) begin
        @(negedge clk);
        assert (addrOk_o && !dataOk_o && !rdValid_o && !wrValid_o)
          else failNow("request was accepted while stall_n was low");
        @(posedge clk);
        #1;
        stall_n = (h == holdCycles - 1);
      end
      @(negedge clk);
      assert (addrOk_o && !dataOk_o)
        else failNow("cache was not idle when the request was presented");
      @(posedge clk);
      #1;
      valid_i = 1'b0;
      stall_n = 1'b1;
      waitCycles = 0;
      done = 1'b0;
      while (!done) begin
        @(negedge clk);
        waitCycles++;
        assert (stall_n || !dataOk_o) else failNow("dataOk_o was high while stall_n was low");
        if (dataOk_o) begin
          done = 1'b1;
          if (isStore) begin
            applyStore(addr, data, mask);
          end else begin
            expWord = modelWord(addr);
            assert (rdData_o === expWord)
              else failNow($sformatf("MISMATCH rdData_o addr=%h expected=%h actual=%h",
                                     addr, expWord, rdData_o));
          end
        end else begin
          assert (!sameLine || waitCycles > 1)
            else failNow("resident line did not answer one cycle after acceptance");
        end
        @(posedge clk);
        #1;
        if (!done) begin
          stall_n = (drawStim() % 8) != 0;
        end
      end
      stall_n = 1'b1;
      prevLine = addr & ~32'h1f;
      prevValid = 1'b1;
    end
    repeat (2) @(posedge clk);
    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

//--- build.f
+incdir+.
dcachePkg.sv
sramIf.sv
dataRam.sv
refillBuffer.sv
dcacheCtrl.sv
dcacheTop.sv
tb_dcache.sv
